// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int HALF_NS      = 2,			// 4 ns period
	parameter int RESET_CYCLES = 10
) (
	output	logic	clock,
	output	logic	rst_n
);

	initial begin
		clock = 1'b0;
		forever #(HALF_NS) clock = ~clock;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
	end

endmodule

// File: bench/tb_dmem.sv
`timescale 1ns/1ps

module tb_dmem;

	localparam int NUM_LANES = 3;
	localparam int TIMEOUT   = 2000;				// Cycles per wait

	logic									clock;
	logic									rst_n;
	pkg_dmem::rt_link_t						rt_in;
	pkg_dmem::ldst_cmd_t	[NUM_LANES:0]	ldst;
	logic					[NUM_LANES:0]	st_valid;
	pkg_dmem::data_t		[NUM_LANES:0]	st_data;
	logic					[NUM_LANES:0]	ld_ready;
	logic					[NUM_LANES:0]	ld_grant;
	logic					[NUM_LANES:0]	ld_valid;
	pkg_dmem::data_t		[NUM_LANES:0]	ld_data;
	logic					[NUM_LANES:0]	st_ready;
	logic					[NUM_LANES:0]	st_grant;
	logic					[NUM_LANES:0]	st_ack;

	pkg_dmem::data_t	model [NUM_LANES+1][2**pkg_dmem::ADDR_W];	// Expected bank contents
	pkg_dmem::data_t	fill_q[$];					// Payload of the next packet
	pkg_dmem::data_t	store_q[$];					// Words of the next store stream
	int					seed;
	int					checks;
	int					errors;

	tb_clock i_clock (.clock(clock), .rst_n(rst_n));

	dmem #(.NUM_LANES(NUM_LANES)) i_dut (.*);

	//////////////////////////////////////////////////
	// Stimulus helpers

	function automatic pkg_dmem::data_t pattern_word(input int lane, input int a);
		return {4'hd, 4'(lane), 8'(a), 8'(a) ^ 8'h5a, 8'(a * 3 + lane)};
	endfunction

	task automatic send_packet(input int lane, input pkg_dmem::addr_t addr);
		pkg_dmem::rt_hdr_t	hdr;
		hdr.lane = pkg_dmem::lane_t'(lane);
		hdr.addr = addr;
		hdr.pad  = '0;
		@(negedge clock);
		rt_in.req      = 1'b1;
		rt_in.rls      = (fill_q.size() == 0);
		rt_in.word.hdr = hdr;
		foreach (fill_q[k]) begin
			@(negedge clock);
			rt_in.rls       = (k == fill_q.size() - 1);
			rt_in.word.data = fill_q[k];
			if (lane <= NUM_LANES) begin
				model[lane][pkg_dmem::addr_t'(int'(addr) + k)] = fill_q[k];
			end
		end
		@(negedge clock);
		rt_in = '0;
		repeat (NUM_LANES + 2) @(negedge clock);	// Last word reaches the far bank
	endtask

	// Returns on the falling edge after the grant, with the request dropped
	task automatic wait_grant(input string name, input int lane, input logic store,
			output logic ok);
		int t;
		t = 0;
		#1;
		while (!(store ? st_grant[lane] : ld_grant[lane]) && t < TIMEOUT) begin
			@(negedge clock);
			#1;
			t++;
		end
		ok = store ? st_grant[lane] : ld_grant[lane];
		@(negedge clock);
		if (store) begin
			ldst[lane].st.req = 1'b0;
		end else begin
			ldst[lane].ld.req = 1'b0;
		end
		if (!ok) begin
			errors++;
			$display("%s: no grant on lane %0d before timeout", name, lane);
		end
	endtask

	task automatic load_stream(input string name, input int lane, input pkg_dmem::addr_t base,
			input pkg_dmem::addr_t stride, input int len);
		int					t;
		int					cnt;
		logic				ok;
		pkg_dmem::addr_t	a;
		@(negedge clock);
		ldst[lane].ld.req    = 1'b1;
		ldst[lane].ld.base   = base;
		ldst[lane].ld.stride = stride;
		ldst[lane].ld.len    = pkg_dmem::addr_t'(len);
		wait_grant(name, lane, 1'b0, ok);
		if (!ok) begin
			return;
		end
		cnt = 0;
		t   = 0;
		a   = base;
		#1;
		while (!ld_ready[lane] && t < TIMEOUT) begin
			if (ld_valid[lane]) begin
				checks++;
				if (ld_data[lane] !== model[lane][a]) begin
					errors++;
					$display("Mismatch %s: lane %0d addr %h expected %h actual %h",
						name, lane, a, model[lane][a], ld_data[lane]);
				end
				a = a + stride;
				cnt++;
			end
			@(negedge clock);
			#1;
			t++;
		end
		checks++;
		if (t >= TIMEOUT) begin
			errors++;
			$display("%s: load on lane %0d never released ld_ready", name, lane);
		end else if (cnt != len || ld_valid[lane]) begin
			errors++;
			$display("Mismatch %s: lane %0d valid count expected %0d actual %0d",
				name, lane, len, cnt + int'(ld_valid[lane]));
		end
	endtask

	task automatic store_stream(input string name, input int lane, input pkg_dmem::addr_t base,
			input pkg_dmem::addr_t stride);
		int					t;
		int					k;
		int					idle;
		logic				ok;
		pkg_dmem::addr_t	a;
		@(negedge clock);
		ldst[lane].st.req    = 1'b1;
		ldst[lane].st.base   = base;
		ldst[lane].st.stride = stride;
		ldst[lane].st.len    = pkg_dmem::addr_t'(store_q.size());
		wait_grant(name, lane, 1'b1, ok);
		if (!ok) begin
			return;
		end
		k    = 0;
		t    = 0;
		idle = 0;
		a    = base;
		while (!st_ready[lane] && t < TIMEOUT) begin
			if (k < store_q.size()) begin
				st_valid[lane] = 1'b1;			// Held until acked
				st_data[lane]  = store_q[k];
			end else begin
				st_valid[lane] = 1'b0;			// All words acked, stream still open
				idle++;
			end
			#1;
			if (st_ack[lane]) begin
				if (k < store_q.size()) begin
					model[lane][a] = store_q[k];
					a = a + stride;
				end
				k++;
			end
			@(negedge clock);
			t++;
		end
		st_valid[lane] = 1'b0;
		checks++;
		if (t >= TIMEOUT) begin
			errors++;
			$display("%s: store on lane %0d timed out after %0d acks", name, lane, k);
		end else if (k != store_q.size()) begin
			errors++;
			$display("Mismatch %s: lane %0d ack count expected %0d actual %0d",
				name, lane, store_q.size(), k);
		end else if (idle != 0) begin
			errors++;
			$display("%s: st_ready on lane %0d came back %0d cycles late", name, lane, idle);
		end
	endtask

	task automatic random_words(ref pkg_dmem::data_t q[$], input int n);
		q.delete();
		for (int k = 0; k < n; k++) begin
			q.push_back(pkg_dmem::data_t'($random(seed)));
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests

	task automatic router_fill();
		int					e;
		pkg_dmem::addr_t	h;
		e = errors;
		for (int l = 0; l <= NUM_LANES; l++) begin
			h = pkg_dmem::addr_t'(l * 40 + 7);
			fill_q.delete();
			for (int k = 0; k < 2**pkg_dmem::ADDR_W; k++) begin
				fill_q.push_back(pattern_word(l, int'(h) + k));	// Covers the whole bank
			end
			send_packet(l, h);
			load_stream("router_fill", l, h, 8'd1, 64);
		end
		$display("router_fill: %0d errors", errors - e);
	endtask

	task automatic strided_streams();
		int e;
		e = errors;
		load_stream("strided_wrap", 1, 8'hf0, 8'd3, 40);	// Crosses the top of the bank
		random_words(store_q, 20);
		store_stream("strided_store", 3, 8'h20, 8'd5);
		load_stream("strided_store", 3, 8'h20, 8'd1, 100);
		$display("strided_streams: %0d errors", errors - e);
	endtask

	task automatic fill_and_store();
		int e;
		e = errors;
		random_words(fill_q, 24);
		random_words(store_q, 24);
		fork
			send_packet(2, 8'h40);
			store_stream("fill_and_store", 2, 8'h90, 8'd1);
		join
		load_stream("fill_and_store", 2, 8'h40, 8'd1, 24);
		load_stream("fill_and_store", 2, 8'h90, 8'd1, 24);
		$display("fill_and_store: %0d errors", errors - e);
	endtask

	task automatic lane_range();
		int e;
		e = errors;
		random_words(fill_q, 8);
		send_packet(9, 8'h10);					// No bank answers to lane 9
		for (int l = 0; l <= NUM_LANES; l++) begin
			load_stream("lane_range", l, 8'h10, 8'd1, 8);
		end
		$display("lane_range: %0d errors", errors - e);
	endtask

	task automatic random_streams();
		int					e;
		int					n;
		pkg_dmem::addr_t	base;
		pkg_dmem::addr_t	stride;
		e = errors;
		for (int l = 0; l <= NUM_LANES; l++) begin
			base   = pkg_dmem::addr_t'($random(seed));
			stride = pkg_dmem::addr_t'($random(seed));
			n      = 1 + ($random(seed) & 31);
			random_words(store_q, n);
			store_stream("random_streams", l, base, stride);
			load_stream("random_streams", l, base, stride, n);
			load_stream("random_streams", l, base, 8'd1, 255);
		end
		$display("random_streams: %0d errors", errors - e);
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		int t;
		rt_in    = '0;
		ldst     = '0;
		st_valid = '0;
		st_data  = '0;
		seed     = 32'hc86beb72;
		checks   = 0;
		errors   = 0;
		t        = 0;
		while (rst_n !== 1'b1 && t < 100) begin
			@(negedge clock);
			t++;
		end
		if (rst_n !== 1'b1) begin
			errors++;
			$display("Reset was never released");
		end
		router_fill();
		strided_streams();
		fill_and_store();
		lane_range();
		random_streams();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: compile.f
verilog/pkg_dmem.sv
verilog/stride_agu.sv
verilog/dmem_router.sv
verilog/dmem_bank.sv
verilog/dmem.sv
bench/tb_clock.sv
bench/tb_dmem.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the dmem testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_dmem \
	-Mdir obj_dir -o tb_dmem \
	&& ./obj_dir/tb_dmem | tee sim.log \
	|| { echo "Verilator build or run failed"; exit 1; }
grep -q "Test OK" sim.log && exit 0 || exit 1

// File: verilog/dmem.sv
`timescale 1ns/1ps

module dmem #(
	parameter int NUM_LANES = 3					// Vector lanes, lane 0 is scalar
) (
	input	logic										clock,
	input	logic										rst_n,
	input	pkg_dmem::rt_link_t							rt_in,
	input	pkg_dmem::ldst_cmd_t	[NUM_LANES:0]		ldst,
	input	logic					[NUM_LANES:0]		st_valid,
	input	pkg_dmem::data_t		[NUM_LANES:0]		st_data,
	output	logic					[NUM_LANES:0]		ld_ready,
	output	logic					[NUM_LANES:0]		ld_grant,
	output	logic					[NUM_LANES:0]		ld_valid,
	output	pkg_dmem::data_t		[NUM_LANES:0]		ld_data,
	output	logic					[NUM_LANES:0]		st_ready,
	output	logic					[NUM_LANES:0]		st_grant,
	output	logic					[NUM_LANES:0]		st_ack
);

	//////////////////////////////////////////////////
	// Router chain, one hop per lane

	pkg_dmem::rt_link_t	[NUM_LANES+1:0]	rt_chain;	// Top entry is left open
	pkg_dmem::rt_link_t	[NUM_LANES:0]	rt_local;

	assign rt_chain[0] = rt_in;

	for (genvar i = 0; i <= NUM_LANES; i++) begin : g_lane

		dmem_router #(
			.LANE_ID	(i)
		) i_router (
			.clock		(clock),
			.rst_n		(rst_n),
			.rt_in		(rt_chain[i]),
			.rt_local	(rt_local[i]),
			.rt_next	(rt_chain[i+1])		// Dropped past the last lane
		);

		dmem_bank #(
			.LANE_ID	(i)
		) i_bank (
			.clock		(clock),
			.rst_n		(rst_n),
			.rt_in		(rt_local[i]),
			.cmd		(ldst[i]),
			.st_valid	(st_valid[i]),
			.st_data	(st_data[i]),
			.ld_ready	(ld_ready[i]),
			.ld_grant	(ld_grant[i]),
			.ld_valid	(ld_valid[i]),
			.ld_data	(ld_data[i]),
			.st_ready	(st_ready[i]),
			.st_grant	(st_grant[i]),
			.st_ack		(st_ack[i])
		);

	end

endmodule

// File: verilog/dmem_bank.sv
`timescale 1ns/1ps

module dmem_bank #(
	parameter int LANE_ID = 0
) (
	input	logic					clock,
	input	logic					rst_n,
	input	pkg_dmem::rt_link_t		rt_in,		// Fill from router
	input	pkg_dmem::ldst_cmd_t	cmd,
	input	logic					st_valid,
	input	pkg_dmem::data_t		st_data,
	output	logic					ld_ready,
	output	logic					ld_grant,
	output	logic					ld_valid,
	output	pkg_dmem::data_t		ld_data,
	output	logic					st_ready,
	output	logic					st_grant,
	output	logic					st_ack
);

	pkg_dmem::data_t	mem [2**pkg_dmem::ADDR_W];

	logic				in_pkt_q;
	pkg_dmem::addr_t	fill_addr_q;
	logic				fill_we;
	logic				we;
	pkg_dmem::addr_t	waddr;
	pkg_dmem::data_t	wdata;
	pkg_dmem::addr_t	ld_addr;
	logic				ld_busy;
	pkg_dmem::addr_t	st_addr;
	logic				st_busy;
	logic				st_last;

	//////////////////////////////////////////////////
	// Router fill

	assign fill_we = rt_in.req & in_pkt_q;		// Payload words only

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			in_pkt_q <= 1'b0;
		end else if (rt_in.req) begin
			if (!in_pkt_q) begin
				// Header must name this lane
				in_pkt_q <= ~rt_in.rls &
					(rt_in.word.hdr.lane == pkg_dmem::lane_t'(LANE_ID));
			end else if (rt_in.rls) begin
				in_pkt_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rt_in.req) begin
			fill_addr_q <= in_pkt_q ? fill_addr_q + 1'b1 : rt_in.word.hdr.addr;
		end
	end

	//////////////////////////////////////////////////
	// Write port arbitration

	assign st_ack = st_valid & st_busy & ~fill_we;	// Fill wins the port
	assign we     = fill_we | st_ack;
	assign waddr  = fill_we ? fill_addr_q : st_addr;
	assign wdata  = fill_we ? rt_in.word.data : st_data;

	always_ff @(posedge clock) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	//////////////////////////////////////////////////
	// Load stream

	assign ld_grant = cmd.ld.req & ld_ready;

	stride_agu i_ld_agu (
		.clock	(clock),
		.rst_n	(rst_n),
		.start	(ld_grant),
		.cmd	(cmd.ld),
		.step	(ld_busy),				// One word per cycle
		.addr	(ld_addr),
		.busy	(ld_busy),
		.last	()
	);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			ld_valid <= 1'b0;
			ld_ready <= 1'b1;
		end else begin
			ld_valid <= ld_busy;
			if (ld_grant) begin
				ld_ready <= 1'b0;
			end else if (!ld_busy) begin
				ld_ready <= 1'b1;			// Up after the last valid
			end
		end
	end

	always_ff @(posedge clock) begin
		ld_data <= mem[ld_addr];
	end

	//////////////////////////////////////////////////
	// Store stream

	assign st_grant = cmd.st.req & st_ready;

	stride_agu i_st_agu (
		.clock	(clock),
		.rst_n	(rst_n),
		.start	(st_grant),
		.cmd	(cmd.st),
		.step	(st_ack),
		.addr	(st_addr),
		.busy	(st_busy),
		.last	(st_last)
	);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			st_ready <= 1'b1;
		end else if (st_grant) begin
			st_ready <= 1'b0;
		end else if ((st_ack & st_last) | ~st_busy) begin
			st_ready <= 1'b1;
		end
	end

endmodule

// File: verilog/dmem_router.sv
`timescale 1ns/1ps

module dmem_router #(
	parameter int LANE_ID = 0
) (
	input	logic					clock,
	input	logic					rst_n,
	input	pkg_dmem::rt_link_t		rt_in,
	output	pkg_dmem::rt_link_t		rt_local,	// To own bank
	output	pkg_dmem::rt_link_t		rt_next		// To next hop
);

	logic				in_pkt_q;				// Past the header
	logic				sel_local_q;			// Choice held for the body
	logic				hit;
	logic				to_local;
	logic				local_req_q;
	logic				local_rls_q;
	logic				next_req_q;
	logic				next_rls_q;
	pkg_dmem::rt_word_u	word_q;

	// Header lane is only meaningful on the first word
	assign hit      = (rt_in.word.hdr.lane == pkg_dmem::lane_t'(LANE_ID));
	assign to_local = in_pkt_q ? sel_local_q : hit;

	//////////////////////////////////////////////////
	// Packet tracking

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			in_pkt_q    <= 1'b0;
			sel_local_q <= 1'b0;
		end else if (rt_in.req) begin
			if (!in_pkt_q) begin
				sel_local_q <= hit;
			end
			in_pkt_q <= ~rt_in.rls;				// Release closes the packet
		end
	end

	//////////////////////////////////////////////////
	// One registered hop

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			local_req_q <= 1'b0;
			local_rls_q <= 1'b0;
			next_req_q  <= 1'b0;
			next_rls_q  <= 1'b0;
		end else begin
			local_req_q <= rt_in.req & to_local;
			local_rls_q <= rt_in.req & rt_in.rls & to_local;
			next_req_q  <= rt_in.req & ~to_local;
			next_rls_q  <= rt_in.req & rt_in.rls & ~to_local;
		end
	end

	always_ff @(posedge clock) begin
		word_q <= rt_in.word;
	end

	assign rt_local.req  = local_req_q;
	assign rt_local.rls  = local_rls_q;
	assign rt_local.word = word_q;
	assign rt_next.req   = next_req_q;
	assign rt_next.rls   = next_rls_q;
	assign rt_next.word  = word_q;

endmodule

// File: verilog/pkg_dmem.sv
package pkg_dmem;

	//////////////////////////////////////////////////
	// Widths

	localparam int DATA_W = 32;		// Data word
	localparam int ADDR_W = 8;		// Words per bank = 2**ADDR_W
	localparam int LANE_W = 4;		// Lane id

	typedef logic [DATA_W-1:0]	data_t;
	typedef logic [ADDR_W-1:0]	addr_t;
	typedef logic [LANE_W-1:0]	lane_t;

	//////////////////////////////////////////////////
	// Core side stream commands

	typedef struct packed {
		logic	req;						// Held until grant
		addr_t	base;
		addr_t	stride;
		addr_t	len;						// Word count, zero is empty
	} stream_cmd_t;

	typedef struct packed {
		stream_cmd_t	ld;
		stream_cmd_t	st;
	} ldst_cmd_t;

	//////////////////////////////////////////////////
	// Router link

	typedef struct packed {
		lane_t	lane;						// Target bank
		addr_t	addr;						// Start address of the fill
		logic	[DATA_W-LANE_W-ADDR_W-1:0]	pad;
	} rt_hdr_t;

	// First word of a packet is a header, the rest is payload
	typedef union packed {
		rt_hdr_t	hdr;
		data_t		data;
	} rt_word_u;

	typedef struct packed {
		logic		req;					// High for the whole packet
		logic		rls;					// With the last word
		rt_word_u	word;
	} rt_link_t;

endpackage

// File: verilog/stride_agu.sv
`timescale 1ns/1ps

module stride_agu (
	input	logic					clock,
	input	logic					rst_n,
	input	logic					start,		// Load a new stream
	input	pkg_dmem::stream_cmd_t	cmd,
	input	logic					step,		// Advance by one word
	output	pkg_dmem::addr_t		addr,
	output	logic					busy,
	output	logic					last		// Final address of the stream
);

	pkg_dmem::addr_t	stride_q;
	pkg_dmem::addr_t	remain_q;				// Words still to go
	logic				advance;

	assign advance = step & busy;
	assign last    = busy & (remain_q == pkg_dmem::addr_t'(1));

	//////////////////////////////////////////////////
	// Length counter

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			remain_q <= '0;
			busy     <= 1'b0;
		end else if (start) begin
			remain_q <= cmd.len;
			busy     <= (cmd.len != '0);		// Empty stream never goes busy
		end else if (advance) begin
			remain_q <= remain_q - 1'b1;
			if (last) begin
				busy <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Address walk, wraps at the bank size

	always_ff @(posedge clock) begin
		if (start) begin
			addr     <= cmd.base;
			stride_q <= cmd.stride;
		end else if (advance) begin
			addr <= addr + stride_q;
		end
	end

endmodule
